// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_sd_ctrl
RTL_TOP    := sd_ctrl
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only when the pass line shows up in the output
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q -x -F '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/sd_card_model.sv ====
`timescale 1ns/100ps

module sd_card_model (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_sd_clk,
  input  logic        i_cmd,
  input  logic        i_cmd_oe,
  output logic        o_cmd,
  output logic [47:0] o_frame,
  output int          o_frame_count
);

  logic        sd_clk_q;
  logic        rise;
  logic        fall;
  logic [47:0] cap_sr;
  logic [47:0] cap_next;
  logic [5:0]  cap_cnt;
  logic [47:0] resp_sr;
  logic [5:0]  resp_left;  // response bits still to send
  logic [2:0]  resp_wait;  // sd clocks before the answer starts

  assign rise     = i_sd_clk && !sd_clk_q;
  assign fall     = !i_sd_clk && sd_clk_q;
  assign cap_next = {cap_sr[46:0], i_cmd};

  // x^7 + x^3 + 1 over the first 40 frame bits
  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = bits[i] ^ crc[6];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return crc;
  endfunction

  // same index, inverted argument, transmit bit 0
  function automatic logic [47:0] build_response(input logic [47:0] cmd);
    logic [39:0] hdr;
    logic [6:0]  crc;
    hdr = {2'b00, cmd[45:40], ~cmd[39:8]};
    crc = crc7_of(hdr);
    if (cmd[45:40] == 6'd9) begin
      crc[0] = ~crc[0];  // broken crc for index 9
    end
    return {hdr, crc, 1'b1};
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      sd_clk_q      <= 1'b0;
      cap_cnt       <= '0;
      resp_left     <= '0;
      resp_wait     <= '0;
      o_cmd         <= 1'b1;
      o_frame_count <= 0;
    end else begin
      sd_clk_q <= i_sd_clk;
      if (rise && i_cmd_oe) begin
        cap_sr <= cap_next;
        if (cap_cnt == 6'd47) begin
          cap_cnt       <= '0;
          o_frame       <= cap_next;
          o_frame_count <= o_frame_count + 1;
          if (cap_next[45:40] != 6'd5) begin  // index 5 stays silent
            resp_sr   <= build_response(cap_next);
            resp_left <= 6'd48;
            resp_wait <= 3'd4;
          end
        end else begin
          cap_cnt <= cap_cnt + 6'd1;
        end
      end
      // card drives after the falling edge, host samples on the rising one
      if (fall) begin
        if (resp_wait != '0) begin
          resp_wait <= resp_wait - 3'd1;
        end else if (resp_left != '0) begin
          o_cmd     <= resp_sr[47];
          resp_sr   <= {resp_sr[46:0], 1'b1};
          resp_left <= resp_left - 6'd1;
        end else begin
          o_cmd <= 1'b1;  // idle high
        end
      end
    end
  end

endmodule

// ==== dv/tb_sd_ctrl.sv ====
`timescale 1ns/100ps

module tb_sd_ctrl;

  import sd_pkg::*;

  logic                  clk;
  logic                  rst;
  logic                  wr_en;
  logic                  rd_req;
  logic [REG_ADDR_W-1:0] addr;
  logic [REG_DATA_W-1:0] wr_data;
  logic [REG_DATA_W-1:0] rd_data;
  logic                  rd_valid;
  logic                  sd_clk;
  logic                  sd_cmd_o;
  logic                  sd_cmd_oe;
  logic                  sd_en_n;
  logic                  card_cmd;
  logic                  cmd_line;
  logic [47:0]           frame;
  int                    frame_count;
  logic                  sd_clk_q;
  int                    since_rise;
  int                    sd_period;  // system clocks between the last two sd clock rises
  int                    sd_rises;
  int                    checks;
  int                    errors;
  logic [15:0]           lfsr;
  event                  timed_out;

  assign cmd_line = sd_cmd_oe ? sd_cmd_o : card_cmd;

  always #5 clk = ~clk;

  sd_ctrl u_dut (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_wr_en     (wr_en),
    .i_rd_req    (rd_req),
    .i_addr      (addr),
    .i_wr_data   (wr_data),
    .o_rd_data   (rd_data),
    .o_rd_valid  (rd_valid),
    .o_sd_clk    (sd_clk),
    .o_sd_cmd_o  (sd_cmd_o),
    .o_sd_cmd_oe (sd_cmd_oe),
    .i_sd_cmd_i  (cmd_line),
    .o_sd_en_n   (sd_en_n)
  );

  sd_card_model u_card (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_sd_clk      (sd_clk),
    .i_cmd         (sd_cmd_o),
    .i_cmd_oe      (sd_cmd_oe),
    .o_cmd         (card_cmd),
    .o_frame       (frame),
    .o_frame_count (frame_count)
  );

  always @(posedge clk) begin
    if (rst) begin
      sd_clk_q   <= 1'b0;
      since_rise <= 0;
      sd_period  <= 0;
      sd_rises   <= 0;
    end else begin
      sd_clk_q <= sd_clk;
      if (sd_clk && !sd_clk_q) begin
        sd_period  <= since_rise + 1;
        since_rise <= 0;
        sd_rises   <= sd_rises + 1;
      end else begin
        since_rise <= since_rise + 1;
      end
    end
  end

  a_read_latency : assert property (@(posedge clk) disable iff (rst) rd_req |=> rd_valid)
    else report_failure("read data did not come one cycle after the request");
  a_read_no_extra : assert property (@(posedge clk) disable iff (rst) rd_valid |-> $past(rd_req))
    else report_failure("read valid pulsed without a request");

  task automatic report_failure(input string what);
    errors++;
    $display("ERROR %s", what);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (expected === actual)
      else begin
        errors++;
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      end
  endtask

  task automatic finish_run;
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    report_failure({"timeout while waiting for ", what});
    -> timed_out;
  endtask

  // a stuck wait ends the run here
  initial begin
    @(timed_out);
    finish_run;
  end

  // galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = bits[i] ^ crc[6];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return crc;
  endfunction

  function automatic logic [47:0] expected_frame(input logic [5:0] idx, input logic [31:0] arg);
    return {2'b01, idx, arg, crc7_of({2'b01, idx, arg}), 1'b1};
  endfunction

  function automatic int half_period(input int mode);
    return (mode == 0) ? 4 : (mode == 1) ? 2 : 1;
  endfunction

  function automatic logic [REG_DATA_W-1:0] ctrl_word(input logic start, input logic resp,
                                                      input logic [1:0] speed,
                                                      input logic power_off);
    logic [REG_DATA_W-1:0] w;
    w = '0;
    w[CTRL_START_BIT]         = start;
    w[CTRL_RESP_BIT]          = resp;
    w[CTRL_SPEED_LSB +: 2]    = speed;
    w[CTRL_POWER_OFF_BIT]     = power_off;
    return w;
  endfunction

  task automatic write_reg(input logic [REG_ADDR_W-1:0] a, input logic [REG_DATA_W-1:0] d);
    @(posedge clk);
    wr_en   <= 1'b1;
    addr    <= a;
    wr_data <= d;
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic read_reg(input logic [REG_ADDR_W-1:0] a, output logic [REG_DATA_W-1:0] d);
    int cycles;
    cycles = 0;
    @(posedge clk);
    rd_req <= 1'b1;
    addr   <= a;
    @(posedge clk);
    rd_req <= 1'b0;
    while (!rd_valid) begin
      @(posedge clk);
      cycles++;
      if (cycles > 4) begin
        abort_on_timeout("read data");
      end
    end
    d = rd_data;
  endtask

  // poll STATUS until busy drops
  task automatic wait_idle(output logic [STATUS_W-1:0] st);
    logic [REG_DATA_W-1:0] word;
    int                    polls;
    polls = 0;
    read_reg(ADDR_STATUS, word);
    while (word[4]) begin
      polls++;
      if (polls > 1000) begin
        abort_on_timeout("the command to finish");
      end
      read_reg(ADDR_STATUS, word);
    end
    st = word[3:0];
  endtask

  task automatic wait_sd_rises(input int n);
    int target;
    int cycles;
    target = sd_rises + n;
    cycles = 0;
    while (sd_rises < target) begin
      @(posedge clk);
      cycles++;
      if (cycles > 10 * n + 10) begin  // slowest mode is 8 clocks per rise
        abort_on_timeout("sd clock edges");
      end
    end
  endtask

  // frame on the line once cmd_oe is up
  task automatic wait_cmd_driven;
    int cycles;
    cycles = 0;
    while (!sd_cmd_oe) begin
      @(posedge clk);
      cycles++;
      if (cycles > 100) begin
        abort_on_timeout("the command frame to start");
      end
    end
  endtask

  task automatic send_command(input logic [5:0] idx, input logic [31:0] arg,
                              input logic resp, input logic [1:0] speed,
                              output logic [STATUS_W-1:0] st);
    write_reg(ADDR_CMD_INDEX, {26'b0, idx});
    write_reg(ADDR_CMD_ARG, arg);
    write_reg(ADDR_CTRL, ctrl_word(1'b1, resp, speed, 1'b0));
    wait_idle(st);
  endtask

  initial begin
    logic [REG_DATA_W-1:0] word;
    logic [STATUS_W-1:0]   st;
    logic [31:0]           rnd;
    logic [31:0]           arg;
    logic [31:0]           inv;
    logic [5:0]            idx;
    int                    frames_before;
    clk     = 1'b0;
    rst     = 1'b1;
    wr_en   = 1'b0;
    rd_req  = 1'b0;
    addr    = '0;
    wr_data = '0;
    checks  = 0;
    errors  = 0;
    lfsr    = 16'd14378;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    check_value("reset cmd_oe", 64'd0, {63'd0, sd_cmd_oe});
    check_value("reset en_n", 64'd0, {63'd0, sd_en_n});
    read_reg(ADDR_STATUS, word);
    check_value("reset status", 64'd0, {32'd0, word});

    // random frames with responses, every speed mode
    for (int i = 0; i < 8; i++) begin
      random_bits(6, rnd);
      idx = rnd[5:0];
      if (idx == 6'd5 || idx == 6'd9) begin
        idx = idx ^ 6'd1;  // those two have their own tests
      end
      random_bits(32, arg);
      frames_before = frame_count;
      send_command(idx, arg, 1'b1, 2'(i), st);
      check_value("frame count", 64'(frames_before + 1), 64'(frame_count));
      check_value("command frame", {16'd0, expected_frame(idx, arg)}, {16'd0, frame});
      check_value("response status", {60'd0, ST_DONE}, {60'd0, st});
      inv = ~arg;
      read_reg(ADDR_RESP_ARG, word);
      check_value("response argument", {32'd0, inv}, {32'd0, word});
      read_reg(ADDR_RESP_INDEX, word);
      check_value("response index", {58'd0, idx}, {32'd0, word});
    end

    random_bits(32, arg);
    send_command(6'd5, arg, 1'b1, 2'd2, st);
    check_value("no response", {60'd0, ST_NO_RESP}, {60'd0, st});
    random_bits(32, arg);
    send_command(6'd9, arg, 1'b1, 2'd1, st);
    check_value("crc error", {60'd0, ST_CRC_ERR}, {60'd0, st});

    // second start lands while the first frame is on the line
    random_bits(32, arg);
    frames_before = frame_count;
    write_reg(ADDR_CMD_INDEX, 32'd17);
    write_reg(ADDR_CMD_ARG, arg);
    write_reg(ADDR_CTRL, ctrl_word(1'b1, 1'b1, 2'd0, 1'b0));
    wait_cmd_driven;
    write_reg(ADDR_CTRL, ctrl_word(1'b1, 1'b1, 2'd0, 1'b0));
    wait_idle(st);
    check_value("busy gating frames", 64'(frames_before + 1), 64'(frame_count));
    check_value("busy gating status", {60'd0, ST_DONE}, {60'd0, st});

    // no response asked for, card still answers but nobody listens
    inv = ~arg;
    random_bits(32, arg);
    send_command(6'd12, arg, 1'b0, 2'd3, st);
    check_value("no response expected", {60'd0, ST_DONE}, {60'd0, st});
    wait_sd_rises(64);  // card answer is over by now
    read_reg(ADDR_RESP_ARG, word);
    check_value("response argument kept", {32'd0, inv}, {32'd0, word});

    for (int m = 0; m < 4; m++) begin
      write_reg(ADDR_CTRL, ctrl_word(1'b0, 1'b0, 2'(m), 1'b0));
      wait_sd_rises(3);
      check_value("sd clock period", 64'(2 * half_period(m)), 64'(sd_period));
    end

    write_reg(ADDR_CTRL, ctrl_word(1'b0, 1'b0, 2'd0, 1'b1));
    @(posedge clk);
    check_value("power off", 64'd1, {63'd0, sd_en_n});
    write_reg(ADDR_CTRL, ctrl_word(1'b0, 1'b0, 2'd0, 1'b0));
    @(posedge clk);
    check_value("power on", 64'd0, {63'd0, sd_en_n});

    finish_run;
  end

endmodule

// ==== verilog.f ====
verilog/sd_pkg.sv
verilog/sd_crc7.sv
verilog/sd_clk_gen.sv
verilog/sd_cmd_tx.sv
verilog/sd_cmd_rx.sv
verilog/sd_reg_block.sv
verilog/sd_ctrl.sv
dv/sd_card_model.sv
dv/tb_sd_ctrl.sv

// ==== verilog/sd_clk_gen.sv ====
`timescale 1ns/100ps

module sd_clk_gen (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic [sd_pkg::SPEED_W-1:0] i_speed_mode,
  output logic                       o_sd_clk,
  output logic                       o_rise_tick,
  output logic                       o_fall_tick
);

  import sd_pkg::*;

  logic [HALF_CNT_W-1:0] half_len;
  logic [HALF_CNT_W-1:0] half_cnt;  // system clocks left in this half period
  logic                  toggle;

  always_comb begin
    case (i_speed_mode)
      2'd0:    half_len = HALF_PERIOD_SLOW;
      2'd1:    half_len = HALF_PERIOD_MID;
      default: half_len = HALF_PERIOD_FAST;
    endcase
  end

  assign toggle = (half_cnt == '0);

  // ticks line up with the cycle in which o_sd_clk shows the new level
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      half_cnt    <= '0;
      o_sd_clk    <= 1'b0;
      o_rise_tick <= 1'b0;
      o_fall_tick <= 1'b0;
    end else begin
      o_rise_tick <= toggle && !o_sd_clk;
      o_fall_tick <= toggle && o_sd_clk;
      if (toggle) begin
        o_sd_clk <= ~o_sd_clk;
        half_cnt <= half_len - 1'b1;  // a new speed mode is picked up here
      end else begin
        half_cnt <= half_cnt - 1'b1;
      end
    end
  end

  a_ticks_exclusive : assert property (
    @(posedge i_clk) disable iff (i_rst) !(o_rise_tick && o_fall_tick)
  );

endmodule

// ==== verilog/sd_cmd_rx.sv ====
`timescale 1ns/100ps

module sd_cmd_rx (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_rise_tick,
  input  logic                           i_arm,
  input  logic                           i_sd_cmd_i,
  output logic                           o_done,
  output logic [sd_pkg::STATUS_W-1:0]    o_status,
  output logic [sd_pkg::CMD_INDEX_W-1:0] o_index,
  output logic [sd_pkg::CMD_ARG_W-1:0]   o_arg
);

  import sd_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_WAIT_START,
    RX_CAPTURE
  } rx_state_t;

  rx_state_t                state;
  logic [NCR_CNT_W-1:0]     ncr_cnt;
  logic [FRAME_CNT_W-1:0]   bit_cnt;   // bits taken so far, start bit included
  logic [CMD_FRAME_LEN-2:0] frame_sr;
  logic [CMD_FRAME_LEN-1:0] frame;
  logic                     start_seen;
  logic                     capture;
  logic                     last_bit;
  logic                     crc_shift;
  logic [CRC7_W-1:0]        crc;
  logic                     crc_ok;

  // frame as it stands once the bit on the line is taken
  assign frame      = {frame_sr, i_sd_cmd_i};
  assign start_seen = (state == RX_WAIT_START) && !i_sd_cmd_i;
  assign capture    = i_rise_tick && (start_seen || state == RX_CAPTURE);
  assign last_bit   = (state == RX_CAPTURE) && (bit_cnt == FRAME_CNT_W'(CMD_FRAME_LEN - 1));
  assign crc_shift  = i_rise_tick &&
                      (start_seen ||
                       (state == RX_CAPTURE && bit_cnt < FRAME_CNT_W'(CMD_HDR_LEN)));
  assign crc_ok     = (frame[CRC7_W:1] == crc) && frame[0];  // end bit must be 1

  sd_crc7 u_crc7 (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_clear (i_arm),
    .i_shift (crc_shift),
    .i_bit   (i_sd_cmd_i),
    .o_crc   (crc)
  );

  always_ff @(posedge i_clk) begin
    if (capture) begin
      frame_sr <= frame[CMD_FRAME_LEN-2:0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rise_tick && last_bit) begin
      o_index <= frame[CMD_FRAME_LEN-3 -: CMD_INDEX_W];
      o_arg   <= frame[CRC7_W+1 +: CMD_ARG_W];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= RX_IDLE;
      ncr_cnt  <= '0;
      bit_cnt  <= '0;
      o_done   <= 1'b0;
      o_status <= ST_IDLE;
    end else begin
      o_done <= 1'b0;
      if (i_arm) begin
        state   <= RX_WAIT_START;
        ncr_cnt <= '0;
      end else if (i_rise_tick) begin
        case (state)
          RX_WAIT_START: begin
            if (!i_sd_cmd_i) begin
              state   <= RX_CAPTURE;
              bit_cnt <= FRAME_CNT_W'(1);
            end else if (ncr_cnt == NCR_CNT_W'(NCR_MAX - 1)) begin
              state    <= RX_IDLE;  // card never answered
              o_done   <= 1'b1;
              o_status <= ST_NO_RESP;
            end else begin
              ncr_cnt <= ncr_cnt + 1'b1;
            end
          end
          RX_CAPTURE: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit) begin
              state    <= RX_IDLE;
              o_done   <= 1'b1;
              o_status <= crc_ok ? ST_DONE : ST_CRC_ERR;
            end
          end
          default: state <= RX_IDLE;
        endcase
      end
    end
  end

  a_done_single_cycle : assert property (
    @(posedge i_clk) disable iff (i_rst) o_done |=> !o_done
  );

endmodule

// ==== verilog/sd_cmd_tx.sv ====
`timescale 1ns/100ps

module sd_cmd_tx (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_fall_tick,
  input  logic                           i_start,
  input  logic [sd_pkg::CMD_INDEX_W-1:0] i_index,
  input  logic [sd_pkg::CMD_ARG_W-1:0]   i_arg,
  output logic                           o_sd_cmd_o,
  output logic                           o_sd_cmd_oe,
  output logic                           o_done
);

  import sd_pkg::*;

  logic [CMD_HDR_LEN-1:0] hdr_sr;
  logic [FRAME_CNT_W-1:0] bit_cnt;    // frame bits already on the line
  logic [FRAME_CNT_W-1:0] crc_pos;
  logic                   pending;    // start seen, first falling edge not yet
  logic                   hdr_phase;
  logic [CRC7_W-1:0]      crc;

  // header bits go out and into the crc together
  assign hdr_phase = (pending && !o_sd_cmd_oe) ||
                     (o_sd_cmd_oe && bit_cnt < FRAME_CNT_W'(CMD_HDR_LEN));
  assign crc_pos   = FRAME_CNT_W'(CMD_FRAME_LEN - 2) - bit_cnt;  // crc msb first

  sd_crc7 u_crc7 (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_clear (i_start),
    .i_shift (i_fall_tick && hdr_phase),
    .i_bit   (hdr_sr[CMD_HDR_LEN-1]),
    .o_crc   (crc)
  );

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      hdr_sr <= {1'b0, 1'b1, i_index, i_arg};  // start, direction, index, argument
    end else if (i_fall_tick && hdr_phase) begin
      hdr_sr <= {hdr_sr[CMD_HDR_LEN-2:0], 1'b0};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pending     <= 1'b0;
      o_sd_cmd_oe <= 1'b0;
      o_sd_cmd_o  <= 1'b0;
      bit_cnt     <= '0;
      o_done      <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        pending <= 1'b1;
      end
      if (i_fall_tick) begin
        if (pending && !o_sd_cmd_oe) begin
          pending     <= 1'b0;
          o_sd_cmd_oe <= 1'b1;
          o_sd_cmd_o  <= hdr_sr[CMD_HDR_LEN-1];
          bit_cnt     <= FRAME_CNT_W'(1);
        end else if (o_sd_cmd_oe) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (hdr_phase) begin
            o_sd_cmd_o <= hdr_sr[CMD_HDR_LEN-1];
          end else if (bit_cnt < FRAME_CNT_W'(CMD_FRAME_LEN - 1)) begin
            o_sd_cmd_o <= crc[crc_pos[2:0]];
          end else if (bit_cnt == FRAME_CNT_W'(CMD_FRAME_LEN - 1)) begin
            o_sd_cmd_o <= 1'b1;  // end bit
          end else begin
            // end bit has had its full sd clock, release the line
            o_sd_cmd_oe <= 1'b0;
            o_sd_cmd_o  <= 1'b0;
            bit_cnt     <= '0;
            o_done      <= 1'b1;
          end
        end
      end
    end
  end

  a_no_start_while_driving : assert property (
    @(posedge i_clk) disable iff (i_rst) i_start |-> !o_sd_cmd_oe
  );

endmodule

// ==== verilog/sd_crc7.sv ====
`timescale 1ns/100ps

module sd_crc7 (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_clear,
  input  logic                      i_shift,
  input  logic                      i_bit,
  output logic [sd_pkg::CRC7_W-1:0] o_crc
);

  import sd_pkg::*;

  logic fb;

  assign fb = i_bit ^ o_crc[CRC7_W-1];

  // x^7 + x^3 + 1, one data bit per shift
  always_ff @(posedge i_clk) begin
    if (i_rst || i_clear) begin
      o_crc <= '0;
    end else if (i_shift) begin
      o_crc <= {o_crc[5:3], o_crc[2] ^ fb, o_crc[1:0], fb};  // x^3 tap
    end
  end

endmodule

// ==== verilog/sd_ctrl.sv ====
`timescale 1ns/100ps

module sd_ctrl (
  input  logic                          i_clk,
  input  logic                          i_rst,
  // register port
  input  logic                          i_wr_en,
  input  logic                          i_rd_req,
  input  logic [sd_pkg::REG_ADDR_W-1:0] i_addr,
  input  logic [sd_pkg::REG_DATA_W-1:0] i_wr_data,
  output logic [sd_pkg::REG_DATA_W-1:0] o_rd_data,
  output logic                          o_rd_valid,
  // card pins
  output logic                          o_sd_clk,
  output logic                          o_sd_cmd_o,
  output logic                          o_sd_cmd_oe,
  input  logic                          i_sd_cmd_i,
  output logic                          o_sd_en_n      // high powers the card down
);

  logic                           w_rise_tick;
  logic                           w_fall_tick;
  logic                           w_start;
  logic [sd_pkg::CMD_INDEX_W-1:0] w_index;
  logic [sd_pkg::CMD_ARG_W-1:0]   w_arg;
  logic                           w_resp_expected;
  logic [sd_pkg::SPEED_W-1:0]     w_speed_mode;
  logic                           w_tx_done;
  logic                           w_rx_done;
  logic [sd_pkg::STATUS_W-1:0]    w_rx_status;
  logic [sd_pkg::CMD_INDEX_W-1:0] w_rx_index;
  logic [sd_pkg::CMD_ARG_W-1:0]   w_rx_arg;

  sd_reg_block u_reg_block (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_wr_en         (i_wr_en),
    .i_rd_req        (i_rd_req),
    .i_addr          (i_addr),
    .i_wr_data       (i_wr_data),
    .o_rd_data       (o_rd_data),
    .o_rd_valid      (o_rd_valid),
    .o_start         (w_start),
    .o_index         (w_index),
    .o_arg           (w_arg),
    .o_resp_expected (w_resp_expected),
    .o_speed_mode    (w_speed_mode),
    .o_power_off     (o_sd_en_n),
    .i_tx_done       (w_tx_done),
    .i_rx_done       (w_rx_done),
    .i_rx_status     (w_rx_status),
    .i_rx_index      (w_rx_index),
    .i_rx_arg        (w_rx_arg)
  );

  sd_clk_gen u_clk_gen (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_speed_mode (w_speed_mode),
    .o_sd_clk     (o_sd_clk),
    .o_rise_tick  (w_rise_tick),
    .o_fall_tick  (w_fall_tick)
  );

  sd_cmd_tx u_cmd_tx (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_fall_tick (w_fall_tick),
    .i_start     (w_start),
    .i_index     (w_index),
    .i_arg       (w_arg),
    .o_sd_cmd_o  (o_sd_cmd_o),
    .o_sd_cmd_oe (o_sd_cmd_oe),
    .o_done      (w_tx_done)
  );

  sd_cmd_rx u_cmd_rx (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rise_tick (w_rise_tick),
    .i_arm       (w_tx_done & w_resp_expected),  // listen only when a response is due
    .i_sd_cmd_i  (i_sd_cmd_i),
    .o_done      (w_rx_done),
    .o_status    (w_rx_status),
    .o_index     (w_rx_index),
    .o_arg       (w_rx_arg)
  );

endmodule

// ==== verilog/sd_pkg.sv ====
package sd_pkg;

  // register port
  localparam int REG_ADDR_W = 3;
  localparam int REG_DATA_W = 32;

  localparam logic [REG_ADDR_W-1:0] ADDR_CTRL       = 3'd0;
  localparam logic [REG_ADDR_W-1:0] ADDR_CMD_INDEX  = 3'd1;
  localparam logic [REG_ADDR_W-1:0] ADDR_CMD_ARG    = 3'd2;
  localparam logic [REG_ADDR_W-1:0] ADDR_STATUS     = 3'd3;  // read only
  localparam logic [REG_ADDR_W-1:0] ADDR_RESP_ARG   = 3'd4;  // read only
  localparam logic [REG_ADDR_W-1:0] ADDR_RESP_INDEX = 3'd5;  // read only

  // control register fields
  localparam int CTRL_START_BIT     = 0;
  localparam int CTRL_RESP_BIT      = 1;
  localparam int CTRL_SPEED_LSB     = 2;  // two bit field
  localparam int CTRL_POWER_OFF_BIT = 4;

  // command and short response frame
  localparam int CMD_INDEX_W   = 6;
  localparam int CMD_ARG_W     = 32;
  localparam int CMD_FRAME_LEN = 48;
  localparam int CRC7_W        = 7;
  localparam int CMD_HDR_LEN   = CMD_FRAME_LEN - CRC7_W - 1;  // bits covered by the crc
  localparam int FRAME_CNT_W   = $clog2(CMD_FRAME_LEN + 1);

  // start bit window after the command, in sd clocks
  localparam int NCR_MAX   = 64;
  localparam int NCR_CNT_W = $clog2(NCR_MAX);

  // status codes, busy flag sits just above them
  localparam int STATUS_W        = 4;
  localparam int STATUS_BUSY_BIT = 4;
  localparam logic [STATUS_W-1:0] ST_IDLE    = 4'b0000;
  localparam logic [STATUS_W-1:0] ST_DONE    = 4'b1000;
  localparam logic [STATUS_W-1:0] ST_NO_RESP = 4'b1001;
  localparam logic [STATUS_W-1:0] ST_CRC_ERR = 4'b1010;

  // sd clock half periods in system clocks
  localparam int SPEED_W    = 2;
  localparam int HALF_CNT_W = 3;
  localparam logic [HALF_CNT_W-1:0] HALF_PERIOD_SLOW = 3'd4;  // mode 0
  localparam logic [HALF_CNT_W-1:0] HALF_PERIOD_MID  = 3'd2;  // mode 1
  localparam logic [HALF_CNT_W-1:0] HALF_PERIOD_FAST = 3'd1;  // modes 2 and 3

endpackage

// ==== verilog/sd_reg_block.sv ====
`timescale 1ns/100ps

module sd_reg_block (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_wr_en,
  input  logic                           i_rd_req,
  input  logic [sd_pkg::REG_ADDR_W-1:0]  i_addr,
  input  logic [sd_pkg::REG_DATA_W-1:0]  i_wr_data,
  output logic [sd_pkg::REG_DATA_W-1:0]  o_rd_data,
  output logic                           o_rd_valid,
  output logic                           o_start,
  output logic [sd_pkg::CMD_INDEX_W-1:0] o_index,
  output logic [sd_pkg::CMD_ARG_W-1:0]   o_arg,
  output logic                           o_resp_expected,
  output logic [sd_pkg::SPEED_W-1:0]     o_speed_mode,
  output logic                           o_power_off,
  input  logic                           i_tx_done,
  input  logic                           i_rx_done,
  input  logic [sd_pkg::STATUS_W-1:0]    i_rx_status,
  input  logic [sd_pkg::CMD_INDEX_W-1:0] i_rx_index,
  input  logic [sd_pkg::CMD_ARG_W-1:0]   i_rx_arg
);

  import sd_pkg::*;

  logic                   busy;
  logic [STATUS_W-1:0]    status;
  logic [CMD_ARG_W-1:0]   resp_arg;
  logic [CMD_INDEX_W-1:0] resp_index;
  logic                   ctrl_wr;
  logic                   cmd_done;
  logic [REG_DATA_W-1:0]  rd_word;

  assign ctrl_wr  = i_wr_en && (i_addr == ADDR_CTRL);
  // no response asked for, so the frame end closes the command
  assign cmd_done = (i_tx_done && !o_resp_expected) || i_rx_done;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_speed_mode    <= '0;
      o_resp_expected <= 1'b0;
      o_power_off     <= 1'b0;
      o_start         <= 1'b0;
      busy            <= 1'b0;
      status          <= ST_IDLE;
    end else begin
      o_start <= 1'b0;
      if (ctrl_wr) begin
        o_speed_mode    <= i_wr_data[CTRL_SPEED_LSB +: SPEED_W];
        o_resp_expected <= i_wr_data[CTRL_RESP_BIT];
        o_power_off     <= i_wr_data[CTRL_POWER_OFF_BIT];
      end
      if (cmd_done) begin
        busy   <= 1'b0;
        status <= i_rx_done ? i_rx_status : ST_DONE;
      end
      if (ctrl_wr && i_wr_data[CTRL_START_BIT] && !busy) begin
        o_start <= 1'b1;  // start while busy is dropped
        busy    <= 1'b1;
        status  <= ST_IDLE;
      end
    end
  end

  // command fields
  always_ff @(posedge i_clk) begin
    if (i_wr_en && i_addr == ADDR_CMD_INDEX) begin
      o_index <= i_wr_data[CMD_INDEX_W-1:0];
    end
    if (i_wr_en && i_addr == ADDR_CMD_ARG) begin
      o_arg <= i_wr_data[CMD_ARG_W-1:0];
    end
  end

  // a timeout leaves the last response in place
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      resp_arg   <= '0;
      resp_index <= '0;
    end else if (i_rx_done && i_rx_status != ST_NO_RESP) begin
      resp_arg   <= i_rx_arg;
      resp_index <= i_rx_index;
    end
  end

  always_comb begin
    rd_word = '0;
    case (i_addr)
      ADDR_CTRL: begin
        rd_word[CTRL_RESP_BIT]              = o_resp_expected;
        rd_word[CTRL_SPEED_LSB +: SPEED_W]  = o_speed_mode;
        rd_word[CTRL_POWER_OFF_BIT]         = o_power_off;
      end
      ADDR_CMD_INDEX:  rd_word[CMD_INDEX_W-1:0] = o_index;
      ADDR_CMD_ARG:    rd_word[CMD_ARG_W-1:0]   = o_arg;
      ADDR_STATUS: begin
        rd_word[STATUS_BUSY_BIT] = busy;
        rd_word[STATUS_W-1:0]    = status;
      end
      ADDR_RESP_ARG:   rd_word[CMD_ARG_W-1:0]   = resp_arg;
      ADDR_RESP_INDEX: rd_word[CMD_INDEX_W-1:0] = resp_index;
      default:         rd_word = '0;
    endcase
  end

  // read data one cycle after the request
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rd_valid <= 1'b0;
    end else begin
      o_rd_valid <= i_rd_req;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rd_req) begin
      o_rd_data <= rd_word;
    end
  end

  a_rx_done_while_busy : assert property (
    @(posedge i_clk) disable iff (i_rst) i_rx_done |-> busy
  );

endmodule
